// ==== design/nova_io_cfg.svh ====
`ifndef NOVA_IO_CFG_SVH
`define NOVA_IO_CFG_SVH

// instruction fields, bit 0 is the msb
`define NOVA_IO_OPCODE          0:2
`define NOVA_IO_ACC             3:4
`define NOVA_IO_TRANSFER        5:7
`define NOVA_IO_CONTROL         8:9
`define NOVA_IO_DEVICE          10:15
`define NOVA_IO_OPCODE_IO       3'b011

`define NOVA_IO_TRANSFER_NIO    3'd0
`define NOVA_IO_TRANSFER_DIA    3'd1
`define NOVA_IO_TRANSFER_DOA    3'd2
`define NOVA_IO_TRANSFER_DIB    3'd3
`define NOVA_IO_TRANSFER_DOB    3'd4
`define NOVA_IO_TRANSFER_DIC    3'd5
`define NOVA_IO_TRANSFER_DOC    3'd6
`define NOVA_IO_TRANSFER_SKP    3'd7

`define NOVA_IO_CTL_START       2'b01
`define NOVA_IO_CTL_CLEAR       2'b10
`define NOVA_IO_CTL_PULSE       2'b11
`define NOVA_IO_CTL_BITS        14:15   // control code inside a write to reg 00

`define NOVA_IO_ST_BUSY         0
`define NOVA_IO_ST_DONE         1

// bus address split and register selects
`define NOVA_IO_ADR_DEV         0:5
`define NOVA_IO_ADR_SEL         6:7
`define NOVA_IO_REG_CS          2'b00
`define NOVA_IO_REG_A           2'b01
`define NOVA_IO_REG_B           2'b10
`define NOVA_IO_REG_C           2'b11

`define NOVA_DEV_TTY            6'o10
`define NOVA_DEV_RTC            6'o14

`endif

// ==== design/nova_io_pkg.sv ====
package nova_io_pkg;

   // bit 0 is the msb, as on the nova
   typedef logic [0:15] word_t;
   typedef logic [0:5]  dev_t;
   typedef logic [0:7]  bus_adr_t;   // {dev_t, register select}

   typedef logic [0:2]  xfer_t;      // transfer code
   typedef logic [0:1]  ctl_t;       // control code
   typedef logic [0:1]  reg_sel_t;

   // master to device
   typedef struct packed {
      logic     stb;
      logic     we;
      bus_adr_t adr;
      word_t    dout;
   } io_bus_t;

   typedef enum logic [2:0] {
      IO_IDLE = 3'd0,
      IO_WAIT = 3'd1,   // strobe cycle
      IO_READ = 3'd2,
      IO_SKIP = 3'd3,
      IO_CNTR = 3'd4    // control write, if any
   } io_state_e;

endpackage

// ==== design/nova_dev.sv ====
`timescale 1ns/1ps
`include "nova_io_cfg.svh"

module nova_dev #(
   parameter nova_io_pkg::dev_t DEV_NUM     = 6'o0,
   parameter int                BUSY_CYCLES = 20
) (
   input  logic                 pclk,
   input  logic                 prst,
   input  nova_io_pkg::io_bus_t bus,
   input  nova_io_pkg::word_t   rdata_in,
   output nova_io_pkg::word_t   rdata_out
);

   localparam int CNT_W = (BUSY_CYCLES > 0) ? $clog2(BUSY_CYCLES + 1) : 1;

   nova_io_pkg::word_t    reg_a;
   nova_io_pkg::word_t    reg_b;
   nova_io_pkg::word_t    reg_c;
   nova_io_pkg::word_t    status;
   nova_io_pkg::reg_sel_t sel;
   nova_io_pkg::ctl_t     ctl;
   logic                  hit;
   logic                  wr;
   logic                  ctl_wr;
   logic                  busy;
   logic                  done;
   logic [CNT_W-1:0]      cnt;

   assign hit    = bus.adr[`NOVA_IO_ADR_DEV] == DEV_NUM;
   assign sel    = bus.adr[`NOVA_IO_ADR_SEL];
   assign ctl    = bus.dout[`NOVA_IO_CTL_BITS];
   assign wr     = bus.stb && bus.we && hit;
   assign ctl_wr = wr && sel == `NOVA_IO_REG_CS;

   always_ff @(posedge pclk) begin
      if (prst) begin
         reg_a <= '0;
         reg_b <= '0;
         reg_c <= '0;
      end else if (wr) begin
         case (sel)
            `NOVA_IO_REG_A: reg_a <= bus.dout;
            `NOVA_IO_REG_B: reg_b <= bus.dout;
            `NOVA_IO_REG_C: reg_c <= bus.dout;
            default: begin
               if (ctl == `NOVA_IO_CTL_PULSE) begin
                  reg_c <= reg_c + 16'd1;
               end
            end
         endcase
      end
   end

   // done comes BUSY_CYCLES+1 edges after start
   always_ff @(posedge pclk) begin
      if (prst) begin
         busy <= 1'b0;
         done <= 1'b0;
         cnt  <= '0;
      end else if (ctl_wr && ctl == `NOVA_IO_CTL_START) begin
         busy <= 1'b1;
         done <= 1'b0;
         cnt  <= CNT_W'(BUSY_CYCLES);
      end else if (ctl_wr && ctl == `NOVA_IO_CTL_CLEAR) begin
         busy <= 1'b0;
         done <= 1'b0;
      end else if (busy) begin
         if (cnt == '0) begin
            busy <= 1'b0;
            done <= 1'b1;
         end else begin
            cnt <= cnt - CNT_W'(1);
         end
      end
   end

   always_comb begin
      status = '0;
      status[`NOVA_IO_ST_BUSY] = busy;
      status[`NOVA_IO_ST_DONE] = done;
      if (!hit) begin
         rdata_out = rdata_in;   // pass upstream data on
      end else begin
         case (sel)
            `NOVA_IO_REG_CS: rdata_out = status;
            `NOVA_IO_REG_A:  rdata_out = reg_a;
            `NOVA_IO_REG_B:  rdata_out = reg_b;
            default:         rdata_out = reg_c;
         endcase
      end
   end

   a_flags: assert property (@(posedge pclk) disable iff (prst) !(busy && done));

endmodule

// ==== design/nova_io.sv ====
`timescale 1ns/1ps
`include "nova_io_cfg.svh"

module nova_io (
   input  logic                 pclk,
   input  logic                 prst,
   input  nova_io_pkg::word_t   io_inst,
   input  nova_io_pkg::word_t   io_op,
   input  logic                 io_pulse,
   output nova_io_pkg::word_t   io_result,
   output logic                 io_skip,
   output logic                 io_busy,
   output nova_io_pkg::io_bus_t bus,
   input  nova_io_pkg::word_t   bs_din
);

   nova_io_pkg::xfer_t     xfer;
   nova_io_pkg::ctl_t      ctl;
   nova_io_pkg::dev_t      dev;
   nova_io_pkg::reg_sel_t  sel;
   nova_io_pkg::word_t     ctl_word;
   nova_io_pkg::io_state_e state;
   nova_io_pkg::io_state_e state_ret;   // where IO_WAIT goes next

   logic                   is_io;
   logic                   is_read;
   logic                   is_nio;
   logic                   is_skp;
   logic                   ctl_due;
   logic                   skip_hit;
   logic                   start;

   logic                   stb_q;
   logic                   we_q;
   nova_io_pkg::bus_adr_t  adr_q;
   nova_io_pkg::word_t     dout_q;

   assign xfer     = io_inst[`NOVA_IO_TRANSFER];
   assign ctl      = io_inst[`NOVA_IO_CONTROL];
   assign dev      = io_inst[`NOVA_IO_DEVICE];
   assign ctl_word = {14'h0000, ctl};

   assign is_io   = io_inst[`NOVA_IO_OPCODE] == `NOVA_IO_OPCODE_IO;
   assign is_nio  = xfer == `NOVA_IO_TRANSFER_NIO;
   assign is_skp  = xfer == `NOVA_IO_TRANSFER_SKP;
   assign is_read = xfer == `NOVA_IO_TRANSFER_DIA ||
                    xfer == `NOVA_IO_TRANSFER_DIB ||
                    xfer == `NOVA_IO_TRANSFER_DIC;
   assign ctl_due = (ctl != 2'b00) && !is_nio;   // nio already carries its control

   assign start   = io_pulse && is_io && state == nova_io_pkg::IO_IDLE;
   assign io_busy = io_pulse || state != nova_io_pkg::IO_IDLE;

   always_comb begin
      case (xfer)
         `NOVA_IO_TRANSFER_DIA, `NOVA_IO_TRANSFER_DOA: sel = `NOVA_IO_REG_A;
         `NOVA_IO_TRANSFER_DIB, `NOVA_IO_TRANSFER_DOB: sel = `NOVA_IO_REG_B;
         `NOVA_IO_TRANSFER_DIC, `NOVA_IO_TRANSFER_DOC: sel = `NOVA_IO_REG_C;
         default:                                      sel = `NOVA_IO_REG_CS;
      endcase
   end

   always_comb begin
      case (ctl)
         2'b00:   skip_hit = bs_din[`NOVA_IO_ST_BUSY];
         2'b01:   skip_hit = !bs_din[`NOVA_IO_ST_BUSY];
         2'b10:   skip_hit = bs_din[`NOVA_IO_ST_DONE];
         default: skip_hit = !bs_din[`NOVA_IO_ST_DONE];
      endcase
   end

   always_ff @(posedge pclk) begin
      if (prst) begin
         state     <= nova_io_pkg::IO_IDLE;
         state_ret <= nova_io_pkg::IO_IDLE;
         io_result <= '0;
         io_skip   <= 1'b0;
         stb_q     <= 1'b0;
         we_q      <= 1'b0;
      end else begin
         case (state)
            nova_io_pkg::IO_IDLE: begin
               if (io_pulse) begin
                  io_skip <= 1'b0;
               end
               if (start) begin
                  stb_q <= 1'b1;
                  we_q  <= !(is_read || is_skp);
                  state <= nova_io_pkg::IO_WAIT;
                  if (is_read) begin
                     state_ret <= nova_io_pkg::IO_READ;
                  end else if (is_skp) begin
                     state_ret <= nova_io_pkg::IO_SKIP;
                  end else begin
                     state_ret <= nova_io_pkg::IO_CNTR;
                  end
               end
            end
            nova_io_pkg::IO_WAIT: begin
               stb_q <= 1'b0;
               state <= state_ret;
            end
            nova_io_pkg::IO_READ: begin
               io_result <= bs_din;   // adr still on the bus here
               state     <= ctl_due ? nova_io_pkg::IO_CNTR : nova_io_pkg::IO_IDLE;
            end
            nova_io_pkg::IO_SKIP: begin
               io_skip <= skip_hit;
               state   <= nova_io_pkg::IO_IDLE;
            end
            nova_io_pkg::IO_CNTR: begin
               if (ctl_due) begin
                  stb_q     <= 1'b1;
                  we_q      <= 1'b1;
                  state     <= nova_io_pkg::IO_WAIT;
                  state_ret <= nova_io_pkg::IO_IDLE;
               end else begin
                  state <= nova_io_pkg::IO_IDLE;
               end
            end
            default: state <= nova_io_pkg::IO_IDLE;
         endcase
      end
   end

   // address and write data
   always_ff @(posedge pclk) begin
      if (start) begin
         adr_q  <= {dev, sel};
         dout_q <= is_nio ? ctl_word : io_op;
      end else if (state == nova_io_pkg::IO_CNTR) begin
         adr_q  <= {dev, `NOVA_IO_REG_CS};
         dout_q <= ctl_word;
      end
   end

   assign bus = '{stb: stb_q, we: we_q, adr: adr_q, dout: dout_q};

   // cpu must wait for io_busy to drop
   a_pulse_idle: assert property (@(posedge pclk) disable iff (prst)
      io_pulse |-> state == nova_io_pkg::IO_IDLE);

   a_stb_len: assert property (@(posedge pclk) disable iff (prst)
      $past(stb_q, 2) && $past(stb_q) |-> !stb_q);

endmodule

// ==== design/nova_io_sys.sv ====
`timescale 1ns/1ps
`include "nova_io_cfg.svh"

module nova_io_sys (
   input  logic               pclk,
   input  logic               prst,
   input  nova_io_pkg::word_t io_inst,
   input  nova_io_pkg::word_t io_op,
   input  logic               io_pulse,
   output nova_io_pkg::word_t io_result,
   output logic               io_skip,
   output logic               io_busy
);

   nova_io_pkg::io_bus_t bus;
   nova_io_pkg::word_t   tty_rdata;
   nova_io_pkg::word_t   bs_din;   // end of the read chain

   nova_io u_io (
      .pclk      (pclk),
      .prst      (prst),
      .io_inst   (io_inst),
      .io_op     (io_op),
      .io_pulse  (io_pulse),
      .io_result (io_result),
      .io_skip   (io_skip),
      .io_busy   (io_busy),
      .bus       (bus),
      .bs_din    (bs_din)
   );

   // first in chain, nothing upstream
   nova_dev #(
      .DEV_NUM     (`NOVA_DEV_TTY),
      .BUSY_CYCLES (20)
   ) u_tty (
      .pclk      (pclk),
      .prst      (prst),
      .bus       (bus),
      .rdata_in  (16'h0000),
      .rdata_out (tty_rdata)
   );

   nova_dev #(
      .DEV_NUM     (`NOVA_DEV_RTC),
      .BUSY_CYCLES (40)
   ) u_rtc (
      .pclk      (pclk),
      .prst      (prst),
      .bus       (bus),
      .rdata_in  (tty_rdata),
      .rdata_out (bs_din)
   );

endmodule

// ==== sim/nova_io_tb.sv ====
`timescale 1ns/1ps
`include "nova_io_cfg.svh"

module nova_io_tb;

   localparam STIM_FILE      = "sim/nova_io_stim.txt";
   localparam int BUSY_LIMIT = 100;   // per instruction, in cycles
   localparam int DOG_CYCLES = 200;   // watchdog budget per stim line

   typedef struct packed {
      logic [15:0] inst;
      logic [15:0] op;
      logic [1:0]  mode;      // 0 fixed, 1 random write, 2 random readback
      logic [15:0] exp_res;
      logic        exp_skip;
      logic [7:0]  idle;
   } test_t;

   logic               pclk;
   logic               prst;
   nova_io_pkg::word_t io_inst;
   nova_io_pkg::word_t io_op;
   logic               io_pulse;
   nova_io_pkg::word_t io_result;
   logic               io_skip;
   logic               io_busy;

   test_t       tests[$];
   logic [15:0] shadow [0:255];   // random operands by {device, register}
   logic [15:0] last_res;
   int          n_tests;
   int          errors;
   int          failed;

   nova_io_sys dut (
      .pclk      (pclk),
      .prst      (prst),
      .io_inst   (io_inst),
      .io_op     (io_op),
      .io_pulse  (io_pulse),
      .io_result (io_result),
      .io_skip   (io_skip),
      .io_busy   (io_busy)
   );

   initial begin
      pclk = 1'b0;
      forever #5 pclk = ~pclk;
   end

   // data registers only, skp and nio never use the table
   function automatic logic [7:0] reg_key(input nova_io_pkg::word_t w);
      logic [2:0] xfer;
      xfer = w[`NOVA_IO_TRANSFER];
      return {w[`NOVA_IO_DEVICE], 2'((xfer + 3'd1) >> 1)};
   endfunction

   task automatic load_stim(output bit ok);
      int    fd;
      int    code;
      int    n;
      string line;
      logic [15:0] f_inst;
      logic [15:0] f_op;
      logic [15:0] f_exp;
      int    f_mode;
      int    f_skip;
      int    f_idle;
      ok = 1'b0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         code = $fgets(line, fd);
         if (code == 0 || line.len() == 0 || line[0] == "#") begin
            continue;
         end
         n = $sscanf(line, "%h %h %d %h %d %d", f_inst, f_op, f_mode, f_exp, f_skip, f_idle);
         if (n == 6) begin
            tests.push_back('{f_inst, f_op, 2'(f_mode), f_exp, f_skip[0], 8'(f_idle)});
         end else if (line.len() > 1) begin
            $display("stim line could not be parsed: %s", line);
            errors++;
         end
      end
      $fclose(fd);
      ok = tests.size() > 0;
   endtask

   task automatic run_test(input int idx, input test_t t);
      nova_io_pkg::word_t w;
      logic [15:0] op;
      logic [15:0] exp_res;
      logic [7:0]  key;
      int          wait_cnt;
      int          err_before;
      w          = t.inst;
      key        = reg_key(w);
      op         = t.op;
      exp_res    = t.exp_res;
      err_before = errors;
      if (t.mode == 2'd1) begin
         op          = 16'($urandom);
         shadow[key] = op;
         exp_res     = last_res;   // writes leave io_result alone
      end else if (t.mode == 2'd2) begin
         exp_res = shadow[key];
      end

      io_inst  = t.inst;
      io_op    = op;
      io_pulse = 1'b1;
      @(posedge pclk);
      #1;
      io_pulse = 1'b0;

      wait_cnt = 0;
      @(negedge pclk);
      while (io_busy && wait_cnt < BUSY_LIMIT) begin
         @(negedge pclk);
         wait_cnt++;
      end

      if (io_busy) begin
         $display("test %0d: io_busy still high after %0d cycles", idx, BUSY_LIMIT);
         errors++;
      end else begin
         assert (io_result === exp_res) else begin
            $display("mismatch io_result in test %0d: got %h, expected %h",
                     idx, io_result, exp_res);
            errors++;
         end
         assert (io_skip === t.exp_skip) else begin
            $display("mismatch io_skip in test %0d: got %h, expected %h",
                     idx, io_skip, t.exp_skip);
            errors++;
         end
      end
      last_res = exp_res;

      if (errors != err_before) begin
         failed++;
      end
      $display("test %0d inst %h op %h: %s", idx, t.inst, op,
               (errors == err_before) ? "ok" : "FAILED");

      @(posedge pclk);
      #1;
      repeat (t.idle) begin
         @(posedge pclk);
         #1;
      end
   endtask

   initial begin
      bit ok;
      prst     = 1'b1;
      io_inst  = '0;
      io_op    = '0;
      io_pulse = 1'b0;
      last_res = 16'h0000;
      n_tests  = 0;
      errors   = 0;
      failed   = 0;
      void'($urandom(32'h0924_5b38));

      load_stim(ok);
      if (!ok) begin
         $display("no tests could be read from %s", STIM_FILE);
         $display("FAIL: see errors above");
         $finish;
      end else begin
         n_tests = tests.size();
         repeat (5) @(posedge pclk);
         #1;
         prst = 1'b0;
         repeat (2) begin
            @(posedge pclk);
            #1;
         end

         foreach (tests[i]) begin
            run_test(i + 1, tests[i]);
         end

         $display("tests %0d, passed %0d, failed %0d, errors %0d",
                  n_tests, n_tests - failed, failed, errors);
         if (errors == 0) begin
            $display("PASS: all tests");
         end else begin
            $display("FAIL: see errors above");
         end
         $finish;
      end
   end

   // hang guard, sized from the stim length
   initial begin
      wait (n_tests > 0);
      repeat (n_tests * DOG_CYCLES) @(posedge pclk);
      $display("watchdog expired after %0d cycles, the DUT did not finish its instructions",
               n_tests * DOG_CYCLES);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== sim/nova_io_stim.txt ====
# inst(hex) op(hex) mode result(hex) skip idle ; mode 0 uses op and result from this file,
# mode 1 writes a random op (result must hold), mode 2 expects the random op written before
# skip polarity after reset, tty then rtc
6708 0000 0 0000 0 2
6748 0000 0 0000 1 2
6788 0000 0 0000 0 2
67C8 0000 0 0000 1 2
670C 0000 0 0000 0 2
67CC 0000 0 0000 1 2
# data registers, random operands
6208 0000 1 0000 0 1
6408 0000 1 0000 0 1
6608 0000 1 0000 0 1
620C 0000 1 0000 0 1
640C 0000 1 0000 0 1
660C 0000 1 0000 0 1
6108 0000 2 0000 0 1
6308 0000 2 0000 0 1
6508 0000 2 0000 0 1
610C 0000 2 0000 0 1
630C 0000 2 0000 0 1
650C 0000 2 0000 0 1
# unmapped device and non-io words
6110 0000 0 0000 0 1
6208 BEEF 0 0000 0 1
6108 0000 0 BEEF 0 1
6748 0000 0 BEEF 1 1
1234 0000 0 BEEF 0 1
# busy then done, clear, rtc start
6248 1111 0 BEEF 0 0
6708 0000 0 BEEF 1 40
6788 0000 0 BEEF 1 1
6708 0000 0 BEEF 0 1
6088 0000 0 BEEF 0 1
67C8 0000 0 BEEF 1 1
6108 0000 0 1111 0 1
604C 0000 0 1111 0 0
674C 0000 0 1111 0 60
678C 0000 0 1111 1 1
67C8 0000 0 1111 1 1
# pulse increments c
6608 7FFF 0 1111 0 1
65C8 0000 0 7FFF 0 1
6508 0000 0 8000 0 1
660C FFFF 0 8000 0 1
65CC 0000 0 FFFF 0 1
650C 0000 0 0000 0 1

// ==== sim.f ====
+incdir+design
design/nova_io_pkg.sv
design/nova_dev.sv
design/nova_io.sv
design/nova_io_sys.sv
sim/nova_io_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the nova_io testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module nova_io_tb \
   -Mdir "$BUILD_DIR" -o nova_io_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/nova_io_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
   exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0
